// File: filelist.f
verilog/dsp_pkg.sv
verilog/ctrl_pkg.sv
verilog/prbs_gen.sv
verilog/tx_fir.sv
verilog/log_select.sv
verilog/capture_ram.sv
verilog/cmd_decoder.sv
verilog/lab_top.sv
tests/lab_checker.sv
tests/tb_lab_top.sv

// File: run.sh
#!/bin/sh
# build the lab testbench with Verilator, run it into a log and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module tb_lab_top --Mdir "$OBJ" -o tb_lab_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/tb_lab_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '>>> FAIL' "$LOG"; then
    exit 1
fi
exit 0

// File: tests/lab_checker.sv
module lab_checker #(
    parameter int STREAM_LEN = 2560
) (
    input  logic                          CLK100MHZ,
    input  logic                          i_cmd_valid,
    input  logic [ctrl_pkg::CMD_W-1:0]    i_cmd,
    input  logic                          i_rd_valid,
    input  logic [dsp_pkg::RAM_WIDTH-1:0] i_rd_data_a,
    input  logic [dsp_pkg::RAM_WIDTH-1:0] i_rd_data_b,
    input  logic [dsp_pkg::RAM_WIDTH-1:0] i_exp_a [STREAM_LEN],
    input  logic [dsp_pkg::RAM_WIDTH-1:0] i_exp_b [STREAM_LEN],
    input  logic                          i_check,
    input  int                            i_min_offset,
    output int                            o_errors,
    output int                            o_reads,
    output int                            o_offset
);
    import dsp_pkg::*;
    import ctrl_pkg::*;

    localparam int ALIGN_LEN = 12;                          // words used to find the offset
    localparam int MAX_PRINT = 10;

    logic [RAM_WIDTH-1:0]  cap_a [LOG_DEPTH];
    logic [RAM_WIDTH-1:0]  cap_b [LOG_DEPTH];
    logic [LOG_ADDR_W-1:0] addr_q [$];                      // reads still waiting for data
    int                    issue_q [$];
    int                    cycle;

    initial begin
        cycle    = 0;
        o_errors = 0;
        o_reads  = 0;
        o_offset = -1;
    end

    function automatic bit window_matches(input int off);
        for (int k = 0; k < ALIGN_LEN; k++) begin
            if (cap_a[k] !== i_exp_a[off+k] || cap_b[k] !== i_exp_b[off+k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic compare_capture();
        int found;
        int printed;
        found   = -1;
        printed = 0;
        for (int off = i_min_offset; off <= STREAM_LEN - LOG_DEPTH; off++) begin
            if (found < 0 && window_matches(off)) begin
                found = off;                                // same offset for both lanes
            end
        end
        o_offset = found;
        if (found < 0) begin
            $display("Error at %0t: the capture matches no window of the expected stream",
                     $time);
            o_errors++;
        end else begin
            for (int i = 0; i < LOG_DEPTH; i++) begin
                if (cap_a[i] !== i_exp_a[found+i] || cap_b[i] !== i_exp_b[found+i]) begin
                    o_errors++;
                    if (printed < MAX_PRINT) begin
                        $display("Mismatch at %0t: address %0d got %h/%h expected %h/%h",
                                 $time, i, cap_a[i], cap_b[i],
                                 i_exp_a[found+i], i_exp_b[found+i]);
                        printed++;
                    end
                end
            end
        end
    endtask

    always @(posedge CLK100MHZ) begin
        cycle++;
        while (issue_q.size() > 0 && cycle > issue_q[0] + 2) begin
            $display("Error at %0t: read of address %0d returned no data after 2 cycles",
                     $time, addr_q[0]);
            o_errors++;
            void'(issue_q.pop_front());
            void'(addr_q.pop_front());
        end
        if (i_rd_valid) begin
            if (issue_q.size() == 0) begin
                $display("Error at %0t: read data arrived with no read pending", $time);
                o_errors++;
            end else begin
                if (cycle != issue_q[0] + 2) begin
                    $display("Error at %0t: read data came %0d cycles after the command",
                             $time, cycle - issue_q[0]);
                    o_errors++;
                end
                cap_a[addr_q[0]] = i_rd_data_a;
                cap_b[addr_q[0]] = i_rd_data_b;
                void'(issue_q.pop_front());
                void'(addr_q.pop_front());
                o_reads++;
            end
        end
        if (i_cmd_valid && i_cmd[CMD_W-1:OP_LSB] == OP_READ) begin
            issue_q.push_back(cycle);                       // data due 2 edges later
            addr_q.push_back(i_cmd[LOG_ADDR_W-1:0]);
        end
        if (i_check) begin
            compare_capture();
        end
    end

endmodule

// File: tests/tb_lab_top.sv
module tb_lab_top;
    import dsp_pkg::*;
    import ctrl_pkg::*;

    localparam int STREAM_LEN   = 2560;                     // covers two captures plus a period
    localparam int FULL_TIMEOUT = 2 * LOG_DEPTH;
    localparam int READ_TIMEOUT = 64;
    localparam int IDLE_CYCLES  = 2000;

    logic                 CLK100MHZ;
    logic                 i_rst_n;
    logic                 i_cmd_valid;
    logic [CMD_W-1:0]     i_cmd;
    logic                 o_rd_valid;
    logic [RAM_WIDTH-1:0] o_rd_data_a;
    logic [RAM_WIDTH-1:0] o_rd_data_b;
    logic                 o_log_full;

    logic [RAM_WIDTH-1:0] exp_a [STREAM_LEN];
    logic [RAM_WIDTH-1:0] exp_b [STREAM_LEN];
    logic                 bits_1 [STREAM_LEN];
    logic                 bits_2 [STREAM_LEN];
    logic                 check;
    int                   min_offset;
    int                   chk_errors;
    int                   chk_reads;
    int                   chk_offset;
    int                   tb_errors;
    int                   tests_run;
    int                   tests_failed;
    int                   mark;
    int                   reads_issued;
    int                   prbs_offset;
    int                   coefs [NUM_TAPS];

    lab_top i_lab_top (
        .CLK100MHZ  (CLK100MHZ),
        .i_rst_n    (i_rst_n),
        .i_cmd_valid(i_cmd_valid),
        .i_cmd      (i_cmd),
        .o_rd_valid (o_rd_valid),
        .o_rd_data_a(o_rd_data_a),
        .o_rd_data_b(o_rd_data_b),
        .o_log_full (o_log_full)
    );

    lab_checker #(.STREAM_LEN(STREAM_LEN)) u_checker (
        .CLK100MHZ   (CLK100MHZ),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd       (i_cmd),
        .i_rd_valid  (o_rd_valid),
        .i_rd_data_a (o_rd_data_a),
        .i_rd_data_b (o_rd_data_b),
        .i_exp_a     (exp_a),
        .i_exp_b     (exp_b),
        .i_check     (check),
        .i_min_offset(min_offset),
        .o_errors    (chk_errors),
        .o_reads     (chk_reads),
        .o_offset    (chk_offset)
    );

    initial CLK100MHZ = 1'b0;
    always #50 CLK100MHZ = ~CLK100MHZ;

    function automatic logic [PRBS_W-1:0] prbs_next(input logic [PRBS_W-1:0] state);
        return {state[7:0], state[8] ^ state[4]};           // new bit enters at bit 0
    endfunction

    function automatic int fir_ref(input logic [NUM_TAPS-1:0] win, input int c [NUM_TAPS]);
        int sum;
        sum = 0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            sum += win[k] ? c[k] : -c[k];                   // win[k] is the bit k steps back
        end
        return sum;
    endfunction

    function automatic logic [CMD_W-1:0] cmd_word(input op_t op, input int data);
        return {op, data[OP_LSB-1:0]};
    endfunction

    task automatic tick();
        @(posedge CLK100MHZ);
        #1;
    endtask

    task automatic send_cmd(input op_t op, input int data);
        i_cmd_valid = 1'b1;
        i_cmd       = cmd_word(op, data);
        tick();
        i_cmd_valid = 1'b0;
    endtask

    task automatic finish_run();
        $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
                 tests_run - tests_failed, tests_failed, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = tb_errors + chk_errors - mark;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errs);
        end
        mark = tb_errors + chk_errors;
    endtask

    task automatic expect_quiet(input string when);
        if (o_rd_valid !== 1'b0 || o_log_full !== 1'b0) begin
            $display("Mismatch at %0t: read valid %b and full %b %s, both expected low",
                     $time, o_rd_valid, o_log_full, when);
            tb_errors++;
        end
    endtask

    task automatic start_log();
        send_cmd(OP_LOG_START, 0);
        tick();                                             // full flag clears one edge later
        if (o_log_full !== 1'b0) begin
            $display("Mismatch at %0t: o_log_full still high after a log start", $time);
            tb_errors++;
        end
    endtask

    task automatic wait_full();
        int n;
        n = 0;
        while (o_log_full !== 1'b1 && n < FULL_TIMEOUT) begin
            tick();
            n++;
        end
        if (o_log_full !== 1'b1) begin
            $display("Timeout: o_log_full did not rise within %0d cycles", FULL_TIMEOUT);
            tb_errors++;
            finish_run();
        end
    endtask

    task automatic wait_reads();
        int n;
        n = 0;
        while (chk_reads < reads_issued && n < READ_TIMEOUT) begin
            tick();
            n++;
        end
        if (chk_reads < reads_issued) begin
            $display("Timeout: only %0d of %0d read results arrived", chk_reads, reads_issued);
            tb_errors++;
            finish_run();
        end
    endtask

    task automatic read_all();
        for (int a = 0; a < LOG_DEPTH; a++) begin
            send_cmd(OP_READ, a);                           // back to back, one per cycle
        end
        reads_issued += LOG_DEPTH;
        wait_reads();
    endtask

    task automatic run_check(input int from);
        min_offset = from;
        check      = 1'b1;
        tick();
        check      = 1'b0;
    endtask

    task automatic build_streams();
        logic [PRBS_W-1:0] s1;
        logic [PRBS_W-1:0] s2;
        s1 = PRBS_SEED_1;
        s2 = PRBS_SEED_2;
        for (int i = 0; i < STREAM_LEN; i++) begin
            s1 = prbs_next(s1);
            s2 = prbs_next(s2);
            bits_1[i] = s1[0];
            bits_2[i] = s2[0];
        end
    endtask

    task automatic set_prbs_expect();
        for (int i = 0; i < STREAM_LEN; i++) begin
            exp_a[i] = RAM_WIDTH'(bits_1[i]);
            exp_b[i] = RAM_WIDTH'(bits_2[i]);
        end
    endtask

    task automatic set_fir_expect();
        logic [NUM_TAPS-1:0] win_1;
        logic [NUM_TAPS-1:0] win_2;
        for (int i = 0; i < STREAM_LEN; i++) begin
            if (i < NUM_TAPS - 1) begin
                exp_a[i] = 16'h8000;                        // history not complete, never matched
                exp_b[i] = 16'h8000;
            end else begin
                for (int k = 0; k < NUM_TAPS; k++) begin
                    win_1[k] = bits_1[i-k];
                    win_2[k] = bits_2[i-k];
                end
                exp_a[i] = RAM_WIDTH'(fir_ref(win_1, coefs));
                exp_b[i] = RAM_WIDTH'(fir_ref(win_2, coefs));
            end
        end
    endtask

    initial begin
        void'($urandom(32'hb9b2cddb));
        i_rst_n      = 1'b0;
        i_cmd_valid  = 1'b0;
        i_cmd        = '0;
        check        = 1'b0;
        min_offset   = 0;
        tb_errors    = 0;
        tests_run    = 0;
        tests_failed = 0;
        mark         = 0;
        reads_issued = 0;
        build_streams();

        repeat (10) begin
            tick();
            expect_quiet("during reset");
        end
        i_rst_n = 1'b1;
        repeat (5) begin
            tick();
            expect_quiet("after reset");
        end
        send_cmd(OP_SET_ENABLE, 1);
        repeat (IDLE_CYCLES) begin
            tick();
            expect_quiet("before any log start");
        end
        end_test("reset state");

        send_cmd(OP_SET_SOURCE, int'(SRC_PRBS));
        start_log();
        wait_full();
        read_all();
        set_prbs_expect();
        run_check(0);
        prbs_offset = chk_offset;
        end_test("prbs capture");

        send_cmd(OP_READ, 5);
        repeat (3) tick();
        send_cmd(OP_READ, 17);
        send_cmd(OP_READ, 18);
        send_cmd(OP_READ, 1023);
        tick();
        send_cmd(OP_READ, 0);
        reads_issued += 5;
        wait_reads();
        end_test("read latency");

        for (int k = 0; k < NUM_TAPS; k++) begin
            coefs[k] = int'($urandom % 128) - 64;
            send_cmd(OP_SET_COEF, (k << 8) | (coefs[k] & 'hff));
        end
        send_cmd(OP_SET_SOURCE, int'(SRC_FIR));
        send_cmd(OP_SET_ENABLE, 3);
        repeat (8) tick();                                  // fill the FIR history
        start_log();
        wait_full();
        read_all();
        set_fir_expect();
        run_check(NUM_TAPS - 1);
        end_test("filtered capture");

        send_cmd(OP_SET_SOURCE, int'(SRC_PRBS));
        send_cmd(OP_SET_ENABLE, 1);
        start_log();
        wait_full();
        read_all();
        set_prbs_expect();
        run_check(prbs_offset + 1);                         // must sit past the first capture
        end_test("log restart");

        finish_run();
    end

endmodule

// File: verilog/capture_ram.sv
module capture_ram (
    input  logic                            CLK100MHZ,
    input  logic                            i_rst_n,
    input  logic                            i_log_start,
    input  logic                            i_valid,
    input  logic [dsp_pkg::RAM_WIDTH-1:0]   i_data,
    input  logic                            i_rd_req,
    input  logic [ctrl_pkg::LOG_ADDR_W-1:0] i_rd_addr,
    output logic [dsp_pkg::RAM_WIDTH-1:0]   o_rd_data,
    output logic                            o_rd_valid,
    output logic                            o_full
);
    import dsp_pkg::*;
    import ctrl_pkg::*;

    logic [RAM_WIDTH-1:0]  mem [LOG_DEPTH];
    logic [LOG_ADDR_W-1:0] wr_addr;
    logic                  armed;
    logic                  wr_en;

    assign wr_en = armed & i_valid & ~i_log_start;

    always_ff @(posedge CLK100MHZ) begin
        if (!i_rst_n) begin
            wr_addr    <= '0;
            armed      <= 1'b0;                             // idle until the first start
            o_full     <= 1'b0;
            o_rd_valid <= 1'b0;
            o_rd_data  <= '0;
        end else begin
            o_rd_valid <= i_rd_req;
            if (i_rd_req) begin
                o_rd_data <= mem[i_rd_addr];
            end
            if (i_log_start) begin
                wr_addr <= '0;
                armed   <= 1'b1;
                o_full  <= 1'b0;
            end else if (wr_en) begin
                wr_addr <= wr_addr + 1'b1;
                if (wr_addr == LOG_ADDR_W'(LOG_DEPTH - 1)) begin
                    armed  <= 1'b0;                         // last slot, stop here
                    o_full <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (wr_en) begin
            mem[wr_addr] <= i_data;
        end
    end

endmodule

// File: verilog/cmd_decoder.sv
module cmd_decoder (
    input  logic                                CLK100MHZ,
    input  logic                                i_rst_n,
    input  logic                                i_cmd_valid,
    input  logic [ctrl_pkg::CMD_W-1:0]          i_cmd,
    output logic                                o_enable_prbs,
    output logic                                o_enable_fir,
    output dsp_pkg::src_t                       o_source,
    output logic                                o_coef_we,
    output logic [dsp_pkg::TAP_IDX_W-1:0]       o_coef_idx,
    output logic signed [dsp_pkg::COEF_W-1:0]   o_coef,
    output logic                                o_log_start,
    output logic                                o_rd_req,
    output logic [ctrl_pkg::LOG_ADDR_W-1:0]     o_rd_addr
);
    import dsp_pkg::*;
    import ctrl_pkg::*;

    op_t               opcode;
    logic [OP_LSB-1:0] data;

    assign opcode = op_t'(i_cmd[OP_LSB +: OP_W]);
    assign data   = i_cmd[OP_LSB-1:0];

    always_ff @(posedge CLK100MHZ) begin
        if (!i_rst_n) begin
            o_enable_prbs <= 1'b0;
            o_enable_fir  <= 1'b0;
            o_source      <= SRC_PRBS;
            o_coef_we     <= 1'b0;
            o_coef_idx    <= '0;
            o_coef        <= '0;
            o_log_start   <= 1'b0;
            o_rd_req      <= 1'b0;
            o_rd_addr     <= '0;
        end else begin
            o_coef_we   <= 1'b0;                            // strobes last one cycle
            o_log_start <= 1'b0;
            o_rd_req    <= 1'b0;
            if (i_cmd_valid) begin
                case (opcode)
                    OP_SET_ENABLE: begin
                        o_enable_prbs <= data[EN_PRBS_BIT];
                        o_enable_fir  <= data[EN_FIR_BIT];
                    end
                    OP_SET_SOURCE: begin
                        o_source <= src_t'(data[SRC_BIT]);
                    end
                    OP_SET_COEF: begin
                        o_coef_we  <= 1'b1;
                        o_coef_idx <= data[TAP_LSB +: TAP_IDX_W];
                        o_coef     <= $signed(data[COEF_LSB +: COEF_W]);
                    end
                    OP_LOG_START: begin
                        o_log_start <= 1'b1;
                    end
                    OP_READ: begin
                        o_rd_req  <= 1'b1;                  // data comes back one cycle later
                        o_rd_addr <= data[LOG_ADDR_W-1:0];
                    end
                    OP_NOP: begin
                    end
                    default: begin                          // unknown opcode, ignored
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/ctrl_pkg.sv
package ctrl_pkg;

    localparam int CMD_W = 32;
    localparam int OP_LSB = 24;                             // opcode in bits 31..24
    localparam int OP_W = CMD_W - OP_LSB;

    // data field positions, counted from bit 0 of the command
    localparam int EN_PRBS_BIT = 0;
    localparam int EN_FIR_BIT = 1;
    localparam int SRC_BIT = 0;
    localparam int COEF_LSB = 0;                            // coefficient in 7..0
    localparam int TAP_LSB = 8;                             // tap index in 9..8

    localparam int LOG_DEPTH = 1024;
    localparam int LOG_ADDR_W = 10;

    typedef enum logic [OP_W-1:0] {
        OP_NOP        = 8'd0,
        OP_SET_ENABLE = 8'd1,
        OP_SET_SOURCE = 8'd2,
        OP_SET_COEF   = 8'd3,
        OP_LOG_START  = 8'd4,
        OP_READ       = 8'd5
    } op_t;

endpackage

// File: verilog/dsp_pkg.sv
package dsp_pkg;

    localparam int PRBS_W = 9;
    localparam logic [PRBS_W-1:0] PRBS_SEED_1 = 9'h1AA;     // lane 1 reset state
    localparam logic [PRBS_W-1:0] PRBS_SEED_2 = 9'h0F5;     // lane 2 reset state
    localparam int PRBS_TAP_A = 8;                          // x^9 + x^5 + 1
    localparam int PRBS_TAP_B = 4;

    localparam int NUM_TAPS = 4;
    localparam int COEF_W = 8;                              // signed
    localparam int TAP_IDX_W = 2;
    localparam int FIR_W = 10;                              // signed, no saturation

    localparam int RAM_WIDTH = 16;

    typedef enum logic {
        SRC_PRBS = 1'b0,                                    // raw pattern bits
        SRC_FIR  = 1'b1                                     // filtered samples
    } src_t;

endpackage

// File: verilog/lab_top.sv
module lab_top (
    input  logic                          CLK100MHZ,
    input  logic                          i_rst_n,
    input  logic                          i_cmd_valid,
    input  logic [ctrl_pkg::CMD_W-1:0]    i_cmd,
    output logic                          o_rd_valid,
    output logic [dsp_pkg::RAM_WIDTH-1:0] o_rd_data_a,
    output logic [dsp_pkg::RAM_WIDTH-1:0] o_rd_data_b,
    output logic                          o_log_full
);
    import dsp_pkg::*;
    import ctrl_pkg::*;

    logic                    enable_prbs;
    logic                    enable_fir;
    src_t                    source;
    logic                    coef_we;
    logic [TAP_IDX_W-1:0]    coef_idx;
    logic signed [COEF_W-1:0] coef;
    logic                    log_start;
    logic                    rd_req;
    logic [LOG_ADDR_W-1:0]   rd_addr;

    logic                    prbs_bit_1;
    logic                    prbs_bit_2;
    logic                    prbs_valid_1;
    logic                    prbs_valid_2;
    logic signed [FIR_W-1:0] sample_1;
    logic signed [FIR_W-1:0] sample_2;
    logic                    fir_valid_1;
    logic                    fir_valid_2;

    logic [RAM_WIDTH-1:0]    word_a;
    logic [RAM_WIDTH-1:0]    word_b;
    logic                    word_valid;
    logic                    rd_valid_a;
    logic                    rd_valid_b;
    logic                    full_a;
    logic                    full_b;

    assign o_rd_valid = rd_valid_a & rd_valid_b;            // both ports answer together
    assign o_log_full = full_a & full_b;

    cmd_decoder u_cmd_decoder (
        .CLK100MHZ    (CLK100MHZ),
        .i_rst_n      (i_rst_n),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .o_enable_prbs(enable_prbs),
        .o_enable_fir (enable_fir),
        .o_source     (source),
        .o_coef_we    (coef_we),
        .o_coef_idx   (coef_idx),
        .o_coef       (coef),
        .o_log_start  (log_start),
        .o_rd_req     (rd_req),
        .o_rd_addr    (rd_addr)
    );

    prbs_gen #(.SEED(PRBS_SEED_1)) u_prbs_1 (
        .CLK100MHZ(CLK100MHZ),
        .i_rst_n  (i_rst_n),
        .i_enable (enable_prbs),
        .o_bit    (prbs_bit_1),
        .o_valid  (prbs_valid_1)
    );

    prbs_gen #(.SEED(PRBS_SEED_2)) u_prbs_2 (
        .CLK100MHZ(CLK100MHZ),
        .i_rst_n  (i_rst_n),
        .i_enable (enable_prbs),
        .o_bit    (prbs_bit_2),
        .o_valid  (prbs_valid_2)
    );

    tx_fir u_fir_1 (
        .CLK100MHZ (CLK100MHZ),
        .i_rst_n   (i_rst_n),
        .i_enable  (enable_fir),
        .i_valid   (prbs_valid_1),
        .i_bit     (prbs_bit_1),
        .i_coef_we (coef_we),                               // same taps on both lanes
        .i_coef_idx(coef_idx),
        .i_coef    (coef),
        .o_sample  (sample_1),
        .o_valid   (fir_valid_1)
    );

    tx_fir u_fir_2 (
        .CLK100MHZ (CLK100MHZ),
        .i_rst_n   (i_rst_n),
        .i_enable  (enable_fir),
        .i_valid   (prbs_valid_2),
        .i_bit     (prbs_bit_2),
        .i_coef_we (coef_we),
        .i_coef_idx(coef_idx),
        .i_coef    (coef),
        .o_sample  (sample_2),
        .o_valid   (fir_valid_2)
    );

    log_select u_log_select (
        .CLK100MHZ   (CLK100MHZ),
        .i_rst_n     (i_rst_n),
        .i_source    (source),
        .i_bit_1     (prbs_bit_1),
        .i_bit_2     (prbs_bit_2),
        .i_prbs_valid(prbs_valid_1 & prbs_valid_2),         // lanes run in lockstep
        .i_sample_1  (sample_1),
        .i_sample_2  (sample_2),
        .i_fir_valid (fir_valid_1 & fir_valid_2),
        .o_word_a    (word_a),
        .o_word_b    (word_b),
        .o_valid     (word_valid)
    );

    capture_ram u_ram_a (
        .CLK100MHZ  (CLK100MHZ),
        .i_rst_n    (i_rst_n),
        .i_log_start(log_start),
        .i_valid    (word_valid),
        .i_data     (word_a),
        .i_rd_req   (rd_req),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (o_rd_data_a),
        .o_rd_valid (rd_valid_a),
        .o_full     (full_a)
    );

    capture_ram u_ram_b (
        .CLK100MHZ  (CLK100MHZ),
        .i_rst_n    (i_rst_n),
        .i_log_start(log_start),
        .i_valid    (word_valid),
        .i_data     (word_b),
        .i_rd_req   (rd_req),
        .i_rd_addr  (rd_addr),
        .o_rd_data  (o_rd_data_b),
        .o_rd_valid (rd_valid_b),
        .o_full     (full_b)
    );

endmodule

// File: verilog/log_select.sv
module log_select (
    input  logic                              CLK100MHZ,
    input  logic                              i_rst_n,
    input  dsp_pkg::src_t                     i_source,
    input  logic                              i_bit_1,
    input  logic                              i_bit_2,
    input  logic                              i_prbs_valid,
    input  logic signed [dsp_pkg::FIR_W-1:0]  i_sample_1,
    input  logic signed [dsp_pkg::FIR_W-1:0]  i_sample_2,
    input  logic                              i_fir_valid,
    output logic [dsp_pkg::RAM_WIDTH-1:0]     o_word_a,
    output logic [dsp_pkg::RAM_WIDTH-1:0]     o_word_b,
    output logic                              o_valid
);
    import dsp_pkg::*;

    always_ff @(posedge CLK100MHZ) begin
        if (!i_rst_n) begin
            o_word_a <= '0;
            o_word_b <= '0;
            o_valid  <= 1'b0;
        end else begin
            case (i_source)
                SRC_FIR: begin
                    o_word_a <= RAM_WIDTH'(i_sample_1);     // sign extended
                    o_word_b <= RAM_WIDTH'(i_sample_2);
                    o_valid  <= i_fir_valid;
                end
                default: begin
                    o_word_a <= RAM_WIDTH'(i_bit_1);        // zero extended
                    o_word_b <= RAM_WIDTH'(i_bit_2);
                    o_valid  <= i_prbs_valid;
                end
            endcase
        end
    end

endmodule

// File: verilog/prbs_gen.sv
module prbs_gen #(
    parameter logic [dsp_pkg::PRBS_W-1:0] SEED = dsp_pkg::PRBS_SEED_1
) (
    input  logic CLK100MHZ,
    input  logic i_rst_n,
    input  logic i_enable,
    output logic o_bit,
    output logic o_valid
);
    import dsp_pkg::*;

    logic [PRBS_W-1:0] lfsr;
    logic              feedback;

    assign feedback = lfsr[PRBS_TAP_A] ^ lfsr[PRBS_TAP_B];

    always_ff @(posedge CLK100MHZ) begin
        if (!i_rst_n) begin
            lfsr    <= SEED;
            o_bit   <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_enable;                            // state held while disabled
            if (i_enable) begin
                lfsr  <= {lfsr[PRBS_W-2:0], feedback};
                o_bit <= feedback;                          // output is the new bit
            end
        end
    end

endmodule

// File: verilog/tx_fir.sv
module tx_fir (
    input  logic                               CLK100MHZ,
    input  logic                               i_rst_n,
    input  logic                               i_enable,
    input  logic                               i_valid,
    input  logic                               i_bit,
    input  logic                               i_coef_we,
    input  logic [dsp_pkg::TAP_IDX_W-1:0]      i_coef_idx,
    input  logic signed [dsp_pkg::COEF_W-1:0]  i_coef,
    output logic signed [dsp_pkg::FIR_W-1:0]   o_sample,
    output logic                               o_valid
);
    import dsp_pkg::*;

    logic signed [COEF_W-1:0] coef [NUM_TAPS];
    logic signed [1:0]        hist [NUM_TAPS-1];            // older symbols, 0 until filled
    logic signed [1:0]        taps [NUM_TAPS];              // tap 0 is the incoming symbol
    logic signed [FIR_W-1:0]  acc;
    logic                     advance;

    assign advance = i_enable & i_valid;

    always_comb begin
        taps[0] = i_bit ? 2'sd1 : -2'sd1;
        for (int k = 1; k < NUM_TAPS; k++) begin
            taps[k] = hist[k-1];
        end
        acc = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            acc = acc + FIR_W'(coef[k]) * FIR_W'(taps[k]);
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (!i_rst_n) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                coef[k] <= '0;
            end
            for (int k = 0; k < NUM_TAPS - 1; k++) begin
                hist[k] <= '0;
            end
            o_sample <= '0;
            o_valid  <= 1'b0;
        end else begin
            if (i_coef_we) begin
                coef[i_coef_idx] <= i_coef;
            end
            o_valid <= advance;
            if (advance) begin
                for (int k = 0; k < NUM_TAPS - 1; k++) begin
                    hist[k] <= taps[k];                     // shift the history by one
                end
                o_sample <= acc;
            end
        end
    end

endmodule
